// File: rvcore_params.svh
`ifndef RVCORE_PARAMS_SVH
`define RVCORE_PARAMS_SVH

// Address of the first instruction fetched after reset
`define RESET_PC 32'h8000_0000

`define XLEN     32 // Data and address width

`define NUM_REGS 32 // x0..x31

`endif

// File: rvPkg.sv
`default_nettype none

`include "rvcore_params.svh"

package rvPkg;

  typedef logic [`XLEN-1:0]             word_t;
  typedef logic [$clog2(`NUM_REGS)-1:0] regIdx_t;
  typedef logic [6:0]                   opcode_t;

  // RV32I major opcodes
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  localparam word_t INST_EBREAK = 32'h0010_0073;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
  } aluOp_t;

  typedef enum logic [2:0] {
    BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_NONE
  } brCond_t;

  typedef enum logic [1:0] {WB_MEM, WB_ALU, WB_PC4} wbSel_t;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immType_t;

  typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} memOp_t;

  typedef enum logic [2:0] {
    LSU_IDLE, LSU_WADDR, LSU_WRESP, LSU_RADDR, LSU_RDATA
  } lsuState_t;

endpackage

`default_nettype wire

// File: axiLiteIf.sv
`default_nettype none

`include "rvcore_params.svh"

interface axiLiteIf;
  import rvPkg::*;

  word_t              awaddr;
  logic               awvalid;
  logic               awready;
  word_t              wdata;
  logic [`XLEN/8-1:0] wstrb;
  logic               wvalid;
  logic               wready;
  logic [1:0]         bresp;
  logic               bvalid;
  logic               bready;
  word_t              araddr;
  logic               arvalid;
  logic               arready;
  word_t              rdata;
  logic [1:0]         rresp;
  logic               rvalid;
  logic               rready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

endinterface

`default_nettype wire

// File: decoder.sv
`default_nettype none

module decoder (
  input  rvPkg::word_t    inst,
  output rvPkg::aluOp_t   aluOp,
  output rvPkg::brCond_t  brCond,
  output rvPkg::immType_t immType,
  output rvPkg::wbSel_t   wbSel,
  output rvPkg::memOp_t   memOp,
  output logic            regWrite,
  output logic            aluASel,
  output logic            aluBSel,
  output logic            jump,
  output logic            jalr,
  output logic            ebreak
);
  import rvPkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       funct7Alt;

  assign opcode    = inst[6:0];
  assign funct3    = inst[14:12];
  assign funct7Alt = inst[30]; // Picks SUB and SRA

  function automatic aluOp_t arithOp(input logic [2:0] f3, input logic alt);
    aluOp_t op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    aluOp    = ALU_ADD;
    brCond   = BR_NONE;
    immType  = IMM_I;
    wbSel    = WB_ALU;
    memOp    = MEM_NONE;
    regWrite = 1'b0;
    aluASel  = 1'b0;
    aluBSel  = 1'b0;
    jump     = 1'b0;
    jalr     = 1'b0;
    ebreak   = 1'b0;
    case (opcode)
      OPC_LUI: begin
        immType  = IMM_U;
        aluOp    = ALU_PASSB;
        aluBSel  = 1'b1;
        regWrite = 1'b1;
      end
      OPC_AUIPC: begin
        immType  = IMM_U;
        aluASel  = 1'b1;
        aluBSel  = 1'b1;
        regWrite = 1'b1;
      end
      OPC_JAL: begin
        immType  = IMM_J;
        aluASel  = 1'b1; // pc + imm
        aluBSel  = 1'b1;
        wbSel    = WB_PC4;
        regWrite = 1'b1;
        jump     = 1'b1;
      end
      OPC_JALR: begin
        aluBSel  = 1'b1;
        wbSel    = WB_PC4;
        regWrite = 1'b1;
        jalr     = 1'b1;
      end
      OPC_BRANCH: begin
        // ALU sees rs1 and rs2 for the compare, target is formed in the core
        immType = IMM_B;
        aluOp   = ALU_SUB;
        case (funct3)
          3'b000:  brCond = BR_EQ;
          3'b001:  brCond = BR_NE;
          3'b100:  brCond = BR_LT;
          3'b101:  brCond = BR_GE;
          3'b110:  brCond = BR_LTU;
          3'b111:  brCond = BR_GEU;
          default: brCond = BR_NONE;
        endcase
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin // lw only
          aluBSel  = 1'b1;
          memOp    = MEM_LOAD;
          wbSel    = WB_MEM;
          regWrite = 1'b1;
        end
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) begin // sw only
          immType = IMM_S;
          aluBSel = 1'b1;
          memOp   = MEM_STORE;
        end
      end
      OPC_OP_IMM: begin
        aluOp    = arithOp(funct3, funct7Alt && funct3 == 3'b101);
        aluBSel  = 1'b1;
        regWrite = 1'b1;
      end
      OPC_OP: begin
        aluOp    = arithOp(funct3, funct7Alt);
        regWrite = 1'b1;
      end
      OPC_SYSTEM: ebreak = (inst == INST_EBREAK);
      default: ; // Unknown opcode retires as a no-op
    endcase
  end

endmodule

`default_nettype wire

// File: immGen.sv
`default_nettype none

module immGen (
  input  rvPkg::word_t    inst,
  input  rvPkg::immType_t immType,
  output rvPkg::word_t    imm
);
  import rvPkg::*;

  always_comb begin
    case (immType)
      IMM_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      IMM_B:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      IMM_U:   imm = {inst[31:12], 12'b0};
      IMM_J:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = {{20{inst[31]}}, inst[31:20]}; // I type
    endcase
  end

endmodule

`default_nettype wire

// File: regFile.sv
`default_nettype none

`include "rvcore_params.svh"

module regFile (
  input  logic           clk,
  input  logic           rst,
  input  logic           wen,
  input  rvPkg::regIdx_t waddr,
  input  rvPkg::word_t   wdata,
  input  rvPkg::regIdx_t raddr1,
  input  rvPkg::regIdx_t raddr2,
  output rvPkg::word_t   rdata1,
  output rvPkg::word_t   rdata2
);
  import rvPkg::*;

  word_t regs [`NUM_REGS];

  // x0 is cleared by reset and never written, so it always reads zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu (
  input  rvPkg::word_t   a,
  input  rvPkg::word_t   b,
  input  rvPkg::aluOp_t  aluOp,
  input  rvPkg::brCond_t brCond,
  output rvPkg::word_t   result,
  output logic           brTaken
);
  import rvPkg::*;

  always_comb begin
    case (aluOp)
      ALU_ADD:   result = a + b;
      ALU_SUB:   result = a - b;
      ALU_SLL:   result = a << b[4:0];
      ALU_SLT:   result = word_t'($signed(a) < $signed(b));
      ALU_SLTU:  result = word_t'(a < b);
      ALU_XOR:   result = a ^ b;
      ALU_SRL:   result = a >> b[4:0];
      ALU_SRA:   result = word_t'($signed(a) >>> b[4:0]);
      ALU_OR:    result = a | b;
      ALU_AND:   result = a & b;
      ALU_PASSB: result = b; // lui
      default:   result = '0;
    endcase
  end

  always_comb begin
    case (brCond)
      BR_EQ:   brTaken = (a == b);
      BR_NE:   brTaken = (a != b);
      BR_LT:   brTaken = ($signed(a) < $signed(b));
      BR_GE:   brTaken = ($signed(a) >= $signed(b));
      BR_LTU:  brTaken = (a < b);
      BR_GEU:  brTaken = (a >= b);
      default: brTaken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: lsuAxi.sv
`default_nettype none

module lsuAxi (
  input  logic          clk,
  input  logic          rst,
  input  rvPkg::memOp_t memOp,
  input  logic          start,
  input  rvPkg::word_t  addr,
  input  rvPkg::word_t  storeData,
  output rvPkg::word_t  loadData,
  output logic          done,
  axiLiteIf.master      bus
);
  import rvPkg::*;

  lsuState_t state;
  word_t     addrReg;
  word_t     dataReg;
  logic      awvalidReg;
  logic      wvalidReg;
  logic      arvalidReg;
  logic      awLast; // AW accepted now or earlier
  logic      wLast;

  assign bus.awaddr  = addrReg;
  assign bus.awvalid = awvalidReg;
  assign bus.wdata   = dataReg;
  assign bus.wstrb   = '1; // Word stores only
  assign bus.wvalid  = wvalidReg;
  assign bus.bready  = (state == LSU_WRESP);
  assign bus.araddr  = addrReg;
  assign bus.arvalid = arvalidReg;
  assign bus.rready  = (state == LSU_RDATA);

  // Error responses on reads return zero
  assign loadData = bus.rresp[1] ? '0 : bus.rdata;

  assign done = (state == LSU_WRESP && bus.bvalid) || (state == LSU_RDATA && bus.rvalid);

  assign awLast = !awvalidReg || bus.awready;
  assign wLast  = !wvalidReg || bus.wready;

  always_ff @(posedge clk) begin
    if (state == LSU_IDLE && start) begin
      addrReg <= addr;
      dataReg <= storeData;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= LSU_IDLE;
      awvalidReg <= 1'b0;
      wvalidReg  <= 1'b0;
      arvalidReg <= 1'b0;
    end else begin
      case (state)
        LSU_IDLE: begin
          if (start && memOp == MEM_STORE) begin
            state      <= LSU_WADDR;
            awvalidReg <= 1'b1;
            wvalidReg  <= 1'b1;
          end else if (start && memOp == MEM_LOAD) begin
            state      <= LSU_RADDR;
            arvalidReg <= 1'b1;
          end
        end
        LSU_WADDR: begin
          // AW and W may be accepted in either order
          if (bus.awready) awvalidReg <= 1'b0;
          if (bus.wready) wvalidReg <= 1'b0;
          if (awLast && wLast) state <= LSU_WRESP;
        end
        LSU_WRESP: if (bus.bvalid) state <= LSU_IDLE;
        LSU_RADDR: begin
          if (bus.arready) begin
            arvalidReg <= 1'b0;
            state      <= LSU_RDATA;
          end
        end
        LSU_RDATA: if (bus.rvalid) state <= LSU_IDLE;
        default: state <= LSU_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rvCore.sv
`default_nettype none

`include "rvcore_params.svh"

module rvCore (
  input  logic               clk,
  input  logic               rst,
  output rvPkg::word_t       pc,
  input  rvPkg::word_t       inst,
  output logic               halted,
  output rvPkg::word_t       mAwaddr,
  output logic               mAwvalid,
  input  logic               mAwready,
  output rvPkg::word_t       mWdata,
  output logic [`XLEN/8-1:0] mWstrb,
  output logic               mWvalid,
  input  logic               mWready,
  input  logic [1:0]         mBresp,
  input  logic               mBvalid,
  output logic               mBready,
  output rvPkg::word_t       mAraddr,
  output logic               mArvalid,
  input  logic               mArready,
  input  rvPkg::word_t       mRdata,
  input  logic [1:0]         mRresp,
  input  logic               mRvalid,
  output logic               mRready
);
  import rvPkg::*;

  aluOp_t   aluOp;
  brCond_t  brCond;
  immType_t immType;
  wbSel_t   wbSel;
  memOp_t   memOp;
  logic     regWrite;
  logic     aluASel;
  logic     aluBSel;
  logic     jump;
  logic     jalr;
  logic     ebreak;
  logic     brTaken;
  logic     lsuDone;
  logic     stall;
  regIdx_t  rs1;
  regIdx_t  rs2;
  regIdx_t  rd;
  word_t    imm;
  word_t    rs1Data;
  word_t    rs2Data;
  word_t    aluA;
  word_t    aluB;
  word_t    aluResult;
  word_t    loadData;
  word_t    wbData;
  word_t    pcPlus4;
  word_t    pcNext;

  axiLiteIf bus ();

  assign mAwaddr      = bus.awaddr;
  assign mAwvalid     = bus.awvalid;
  assign bus.awready  = mAwready;
  assign mWdata       = bus.wdata;
  assign mWstrb       = bus.wstrb;
  assign mWvalid      = bus.wvalid;
  assign bus.wready   = mWready;
  assign bus.bresp    = mBresp;
  assign bus.bvalid   = mBvalid;
  assign mBready      = bus.bready;
  assign mAraddr      = bus.araddr;
  assign mArvalid     = bus.arvalid;
  assign bus.arready  = mArready;
  assign bus.rdata    = mRdata;
  assign bus.rresp    = mRresp;
  assign bus.rvalid   = mRvalid;
  assign mRready      = bus.rready;

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  decoder uDecoder (
    .inst, .aluOp, .brCond, .immType, .wbSel, .memOp,
    .regWrite, .aluASel, .aluBSel, .jump, .jalr, .ebreak
  );

  immGen uImmGen (.inst, .immType, .imm);

  // Memory instructions hold the core until the bus transaction finishes
  assign stall = (memOp != MEM_NONE) && !lsuDone;

  regFile uRegFile (
    .clk, .rst,
    .wen    (regWrite && !stall && !halted),
    .waddr  (rd),
    .wdata  (wbData),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (rs1Data),
    .rdata2 (rs2Data)
  );

  assign aluA = aluASel ? pc : rs1Data;
  assign aluB = aluBSel ? imm : rs2Data;

  alu uAlu (.a(aluA), .b(aluB), .aluOp, .brCond, .result(aluResult), .brTaken);

  lsuAxi uLsu (
    .clk, .rst, .memOp,
    .start     ((memOp != MEM_NONE) && !halted),
    .addr      (aluResult),
    .storeData (rs2Data),
    .loadData,
    .done      (lsuDone),
    .bus       (bus.master)
  );

  assign pcPlus4 = pc + 32'd4;

  always_comb begin
    case (wbSel)
      WB_MEM:  wbData = loadData;
      WB_PC4:  wbData = pcPlus4;
      default: wbData = aluResult;
    endcase
  end

  always_comb begin
    if (stall || halted) pcNext = pc;
    else if (jalr) pcNext = {aluResult[`XLEN-1:1], 1'b0};
    else if (jump || brTaken) pcNext = pc + imm; // Branch target
    else pcNext = pcPlus4;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= `RESET_PC;
      halted <= 1'b0;
    end else begin
      pc <= pcNext;
      if (ebreak) halted <= 1'b1; // Sticky until reset
    end
  end

endmodule

`default_nettype wire

// File: tbAxiMem.sv
`default_nettype none

module tbAxiMem (
  input  logic         clk,
  input  logic         rst,
  input  rvPkg::word_t awaddr,
  input  logic         awvalid,
  output logic         awready,
  input  rvPkg::word_t wdata,
  input  logic [3:0]   wstrb,
  input  logic         wvalid,
  output logic         wready,
  output logic [1:0]   bresp,
  output logic         bvalid,
  input  logic         bready,
  input  rvPkg::word_t araddr,
  input  logic         arvalid,
  output logic         arready,
  output rvPkg::word_t rdata,
  output logic [1:0]   rresp,
  output logic         rvalid,
  input  logic         rready
);
  import rvPkg::*;

  word_t      mem [256];
  word_t      logAddr [$]; // One entry per completed write
  word_t      logData [$];
  logic [3:0] logStrb [$];
  int         awCount;
  int         wCount;
  int         bCount;
  logic [1:0] awDly, wDly, bDly, arDly, rDly;
  logic       awGot, wGot, arGot;
  word_t      wrAddr, wrData, rdAddr;
  logic [3:0] wrStrb;

  function automatic word_t fillWord(input word_t a);
    return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [1:0] randDelay();
    return 2'($urandom % 4);
  endfunction

  assign bresp = 2'b00;
  assign rresp = 2'b00;

  initial begin
    for (int i = 0; i < 256; i++) mem[i] = fillWord(word_t'(i * 4));
    {awready, wready, bvalid, arready, rvalid} = '0;
    rdata = '0;
    {awDly, wDly, bDly, arDly, rDly} = '0;
    {awGot, wGot, arGot} = '0;
    {awCount, wCount, bCount} = '0;
  end

  // Outputs change 2 units after the edge, like the rest of the stimulus
  always @(posedge clk) begin
    if (rst) begin
      awready <= #2 1'b0;
      wready  <= #2 1'b0;
      bvalid  <= #2 1'b0;
      arready <= #2 1'b0;
      rvalid  <= #2 1'b0;
      {awGot, wGot, arGot} = '0;
    end else begin
      if (awvalid && awready) begin
        awGot = 1'b1;
        wrAddr = awaddr;
        awCount++;
        awready <= #2 1'b0;
      end else if (awvalid && !awGot) begin
        if (awDly == 0) begin
          awready <= #2 1'b1;
          awDly = randDelay();
        end else awDly--;
      end
      if (wvalid && wready) begin
        wGot = 1'b1;
        wrData = wdata;
        wrStrb = wstrb;
        wCount++;
        wready <= #2 1'b0;
      end else if (wvalid && !wGot) begin
        if (wDly == 0) begin
          wready <= #2 1'b1;
          wDly = randDelay();
        end else wDly--;
      end
      if (bvalid && bready) begin
        bvalid <= #2 1'b0;
        mem[wrAddr[9:2]] = wrData;
        logAddr.push_back(wrAddr);
        logData.push_back(wrData);
        logStrb.push_back(wrStrb);
        bCount++;
        awGot = 1'b0;
        wGot = 1'b0;
      end else if (awGot && wGot && !bvalid) begin
        if (bDly == 0) begin
          bvalid <= #2 1'b1;
          bDly = randDelay();
        end else bDly--;
      end
      if (arvalid && arready) begin
        arGot = 1'b1;
        rdAddr = araddr;
        arready <= #2 1'b0;
      end else if (arvalid && !arGot) begin
        if (arDly == 0) begin
          arready <= #2 1'b1;
          arDly = randDelay();
        end else arDly--;
      end
      if (rvalid && rready) begin
        rvalid <= #2 1'b0;
        arGot = 1'b0;
      end else if (arGot && !rvalid && !arready) begin
        if (rDly == 0) begin
          rvalid <= #2 1'b1;
          rdata  <= #2 mem[rdAddr[9:2]];
          rDly = randDelay();
        end else rDly--;
      end
    end
  end

endmodule

`default_nettype wire

// File: tbRvCore.sv
`default_nettype none

`include "rvcore_params.svh"

module tbRvCore;
  import rvPkg::*;

  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam int MAX_CYCLES = 4000; // 5 tests x 60 instructions x 10 cycles, plus margin

  logic       clk, rst, halted;
  word_t      pc, inst, pcOff;
  word_t      mAwaddr, mWdata, mAraddr, mRdata;
  logic [3:0] mWstrb;
  logic [1:0] mBresp, mRresp;
  logic       mAwvalid, mAwready, mWvalid, mWready, mBvalid, mBready;
  logic       mArvalid, mArready, mRvalid, mRready;

  word_t rom [128];
  bit    visited [128];
  word_t expAddr [$];
  word_t expData [$];
  int    ip, errors, tests, cycles, validSeen;

  rvCore dut (
    .clk, .rst, .pc, .inst, .halted,
    .mAwaddr, .mAwvalid, .mAwready, .mWdata, .mWstrb, .mWvalid, .mWready,
    .mBresp, .mBvalid, .mBready, .mAraddr, .mArvalid, .mArready,
    .mRdata, .mRresp, .mRvalid, .mRready
  );

  tbAxiMem axiMem (
    .clk, .rst, .awaddr(mAwaddr), .awvalid(mAwvalid), .awready(mAwready),
    .wdata(mWdata), .wstrb(mWstrb), .wvalid(mWvalid), .wready(mWready),
    .bresp(mBresp), .bvalid(mBvalid), .bready(mBready),
    .araddr(mAraddr), .arvalid(mArvalid), .arready(mArready),
    .rdata(mRdata), .rresp(mRresp), .rvalid(mRvalid), .rready(mRready)
  );

  always #20 clk = ~clk;

  assign pcOff = pc - `RESET_PC;
  assign inst  = (pcOff < 32'd512) ? rom[pcOff[8:2]] : 32'h0000_0013;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, core never halted", cycles);
      $display("sim failed");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (pcOff < 32'd512) visited[pcOff[8:2]] = 1'b1;
      if (halted && (mAwvalid || mWvalid || mArvalid)) validSeen++;
    end
  end

  function automatic word_t encR(input logic alt, input logic [4:0] rs2, rs1,
                                 input logic [2:0] f3, input logic [4:0] rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t encI(input logic [11:0] imm, input logic [4:0] rs1,
                                 input logic [2:0] f3, input logic [4:0] rd,
                                 input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t encS(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t encB(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                 input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // RV32I result rules for the OP and OP-IMM groups
  function automatic word_t opRef(input logic [2:0] f3, input logic alt, input word_t x, y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return {31'b0, $signed(x) < $signed(y)};
      3'd3:    return {31'b0, x < y};
      3'd4:    return x ^ y;
      3'd5:    return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic brRef(input logic [2:0] f3, input word_t x, y);
    case (f3)
      3'd0:    return x == y;
      3'd1:    return x != y;
      3'd4:    return $signed(x) < $signed(y);
      3'd5:    return $signed(x) >= $signed(y);
      3'd6:    return x < y;
      default: return x >= y;
    endcase
  endfunction

  task automatic emit(input word_t w);
    rom[ip] = w;
    ip++;
  endtask

  task automatic loadImm(input logic [4:0] rd, input word_t v);
    word_t t;
    t = v + 32'h800; // Compensates the sign of the low part
    emit({t[31:12], rd, 7'b0110111});
    emit(encI(v[11:0], rd, 3'd0, rd, OP_IMM));
  endtask

  // Stores a register to the next log slot and records what it must hold
  task automatic storeChk(input logic [4:0] rs, input word_t v);
    word_t a;
    a = 32'h100 + word_t'(4 * expAddr.size());
    emit(encS(a[11:0], rs, 5'd0));
    expAddr.push_back(a);
    expData.push_back(v);
  endtask

  task automatic startProg();
    for (int i = 0; i < 128; i++) begin
      rom[i] = INST_EBREAK;
      visited[i] = 1'b0;
    end
    ip = 0;
    expAddr.delete();
    expData.delete();
  endtask

  task automatic runProg();
    axiMem.logAddr.delete();
    axiMem.logData.delete();
    axiMem.logStrb.delete();
    {axiMem.awCount, axiMem.wCount, axiMem.bCount} = '0;
    @(posedge clk);
    #2 rst = 1'b1;
    repeat (8) @(posedge clk);
    #2 rst = 1'b0;
    @(negedge clk);
    while (!halted) @(negedge clk);
  endtask

  task automatic checkLog();
    if (axiMem.logData.size() != expData.size()) begin
      $display("expected %0d stores but the memory saw %0d", expData.size(),
               axiMem.logData.size());
      errors++;
    end else begin
      for (int i = 0; i < expData.size(); i++) begin
        if (axiMem.logAddr[i] != expAddr[i]) begin
          $display("mismatch awaddr exp %h got %h", expAddr[i], axiMem.logAddr[i]);
          errors++;
        end
        if (axiMem.logData[i] != expData[i]) begin
          $display("mismatch wdata exp %h got %h", expData[i], axiMem.logData[i]);
          errors++;
        end
        if (axiMem.logStrb[i] != 4'hF) begin // Word stores only
          $display("mismatch wstrb exp %h got %h", 4'hF, axiMem.logStrb[i]);
          errors++;
        end
      end
    end
  endtask

  task automatic report(input string name, input int errBefore);
    tests++;
    $display("%s: %0d errors", name, errors - errBefore);
  endtask

  task automatic testArith();
    int e;
    word_t a, b, y;
    logic [4:0] rs2;
    e = errors;
    a = 32'hFFFF_FB2E;
    b = 32'h1234_5678;
    startProg();
    emit(encI(12'hB2E, 5'd0, 3'd0, 5'd1, OP_IMM));
    loadImm(5'd2, b);
    emit(encI(12'd7, 5'd0, 3'd0, 5'd4, OP_IMM));
    for (int f3 = 0; f3 < 8; f3++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 0 || f3 == 0 || f3 == 5) begin
          rs2 = (f3 == 1 || f3 == 5) ? 5'd4 : 5'd2; // Shifts use x4 = 7
          y = (rs2 == 5'd4) ? 32'd7 : b;
          emit(encR(1'(alt), rs2, 5'd1, 3'(f3), 5'd3));
          storeChk(5'd3, opRef(3'(f3), 1'(alt), a, y));
        end
        if (alt == 0 || f3 == 5) begin
          y = (f3 == 1 || f3 == 5) ? 32'd9 : 32'hFFFF_FC18;
          // Bit 10 of the immediate picks srai
          emit(encI({y[11], y[10] | 1'(alt), y[9:0]}, 5'd1, 3'(f3), 5'd3, OP_IMM));
          storeChk(5'd3, opRef(3'(f3), 1'(alt), a, y));
        end
      end
    end
    runProg();
    checkLog();
    report("arith", e);
  endtask

  task automatic testJumps();
    int e, k, j, m;
    e = errors;
    startProg();
    emit({20'hABCDE, 5'd1, 7'b0110111});
    storeChk(5'd1, 32'hABCD_E000);
    k = ip;
    emit({20'h00001, 5'd2, 7'b0010111});
    storeChk(5'd2, `RESET_PC + word_t'(4 * k) + 32'h1000);
    j = ip;
    emit(encJ(21'd12, 5'd3));
    emit(encI(12'd99, 5'd0, 3'd0, 5'd6, OP_IMM));
    emit(encI(12'd99, 5'd0, 3'd0, 5'd6, OP_IMM));
    storeChk(5'd3, `RESET_PC + word_t'(4 * j + 4));
    m = ip;
    emit({20'h0, 5'd7, 7'b0010111});
    emit(encI(12'd12, 5'd7, 3'd0, 5'd8, 7'b1100111));
    emit(encI(12'd77, 5'd0, 3'd0, 5'd6, OP_IMM));
    storeChk(5'd8, `RESET_PC + word_t'(4 * m + 8));
    storeChk(5'd6, 32'h0); // Skipped instructions must leave x6 alone
    runProg();
    checkLog();
    if (visited[j + 1] || visited[j + 2] || visited[m + 2]) begin
      $display("pc reached an instruction that a jump should skip");
      errors++;
    end
    if (!visited[j + 3] || !visited[m + 3]) begin
      $display("pc never reached a jump target");
      errors++;
    end
    report("jumps", e);
  endtask

  task automatic testBranches();
    int e;
    int f3s [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
    int ra [12]  = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
    int rb [12]  = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
    word_t regv [4] = '{32'h0, 32'hFFFF_FFFB, 32'h3, 32'h3};
    logic taken;
    e = errors;
    startProg();
    emit(encI(12'hFFB, 5'd0, 3'd0, 5'd1, OP_IMM));
    emit(encI(12'd3, 5'd0, 3'd0, 5'd2, OP_IMM));
    emit(encI(12'd3, 5'd0, 3'd0, 5'd3, OP_IMM));
    for (int i = 0; i < 12; i++) begin
      taken = brRef(3'(f3s[i]), regv[ra[i]], regv[rb[i]]);
      emit(encB(13'd12, 5'(rb[i]), 5'(ra[i]), 3'(f3s[i])));
      emit(encI(12'(100 + i), 5'd0, 3'd0, 5'd5, OP_IMM));
      emit(encJ(21'd8, 5'd0));
      emit(encI(12'(200 + i), 5'd0, 3'd0, 5'd5, OP_IMM));
      storeChk(5'd5, taken ? word_t'(200 + i) : word_t'(100 + i));
    end
    runProg();
    checkLog();
    report("branches", e);
  endtask

  task automatic testLoadStore();
    int e;
    word_t v [4];
    word_t base;
    e = errors;
    startProg();
    base = 32'h100;
    for (int i = 0; i < 4; i++) begin
      v[i] = $urandom;
      loadImm(5'd10, v[i]);
      storeChk(5'd10, v[i]);
    end
    for (int i = 0; i < 4; i++) begin
      emit(encI(12'(base + word_t'(4 * i)), 5'd0, 3'b010, 5'(11 + i), 7'b0000011));
    end
    emit(encR(1'b0, 5'd12, 5'd11, 3'd0, 5'd20));
    storeChk(5'd20, v[0] + v[1]);
    emit(encR(1'b0, 5'd14, 5'd13, 3'd0, 5'd21));
    storeChk(5'd21, v[2] + v[3]);
    emit(encI(12'h300, 5'd0, 3'b010, 5'd15, 7'b0000011)); // Never written
    storeChk(5'd15, axiMem.fillWord(32'h300));
    runProg();
    checkLog();
    if (axiMem.awCount != expData.size() || axiMem.wCount != expData.size() ||
        axiMem.bCount != expData.size()) begin
      $display("handshake counts differ from store count: aw %0d w %0d b %0d",
               axiMem.awCount, axiMem.wCount, axiMem.bCount);
      errors++;
    end
    report("loadstore", e);
  endtask

  task automatic testHalt();
    int e;
    word_t held;
    e = errors;
    startProg();
    emit(encI(12'd55, 5'd0, 3'd0, 5'd0, OP_IMM)); // x0 stays zero
    storeChk(5'd0, 32'h0);
    emit(INST_EBREAK);
    emit(encI(12'd1, 5'd0, 3'd0, 5'd9, OP_IMM));
    emit(encS(12'h3F0, 5'd9, 5'd0));
    runProg();
    held = pc;
    validSeen = 0;
    repeat (20) begin
      @(negedge clk);
      if (pc != held) begin
        $display("mismatch pc exp %h got %h", held, pc);
        errors++;
      end
    end
    if (validSeen != 0) begin
      $display("bus valid raised %0d times after halt", validSeen);
      errors++;
    end
    checkLog();
    report("halt", e);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    {errors, tests, cycles, validSeen} = '0;
    void'($urandom(32'h44bc16f0));
    testArith();
    testJumps();
    testBranches();
    testLoadStore();
    testHalt();
    $display("tests %0d, errors %0d, cycles %0d", tests, errors, cycles);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
rvPkg.sv
axiLiteIf.sv
decoder.sv
immGen.sv
regFile.sv
alu.sv
lsuAxi.sv
rvCore.sv
tbAxiMem.sv
tbRvCore.sv

// File: run.sh
#!/bin/bash
# Builds and runs the testbench with Verilator, then scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbRvCore -f src.f -o simTb > build.log 2>&1 \
  && ./obj_dir/simTb > sim.log 2>&1 \
  || { echo "build or run failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
